// ==== project.f ====
rtl/rv_exec_pkg.sv
rtl/rv_decode.sv
rtl/rv_reg_file.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_apb_issue.sv
rtl/rv_exec_top.sv
tb/tb_clock_gen.sv
tb/rv_exec_props.sv
tb/rv_exec_tb.sv

// ==== rtl/rv_apb_issue.sv ====
// APB slave holding the issue register, sequencing one instruction and serving readback
`timescale 1ns/10ps
module rv_apb_issue (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  rv_exec_pkg::apb_addr_t paddr_i,
    input  rv_exec_pkg::word_t     pwdata_i,
    output rv_exec_pkg::word_t     prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    input  logic                   illegal_i,
    input  logic                   halt_i,
    input  logic                   retire_i,
    input  rv_exec_pkg::word_t     pc_i,
    input  logic [15:0]            retire_count_i,
    input  rv_exec_pkg::word_t     reg_rdata_i,
    output rv_exec_pkg::word_t     instr_o,
    output logic                   issue_o,
    output logic                   halted_o,
    output rv_exec_pkg::reg_addr_t reg_raddr_o,
    output logic                   pc_wen_o,
    output rv_exec_pkg::word_t     pc_wdata_o
);
    import rv_exec_pkg::*;

    issue_state_t state_q;
    word_t        instr_q;
    logic         halted_q;
    logic         illegal_q;
    logic         done;
    logic         err;
    logic         reg_hit;
    logic         instr_wr;
    logic         start;
    word_t        status;

    assign pready_o = (state_q == ISSUE_IDLE);
    assign done     = psel_i & penable_i & pready_o;

    assign reg_hit     = (paddr_i[11:7] == ADDR_REG_BASE[11:7]) && (paddr_i[1:0] == 2'b00);
    assign reg_raddr_o = paddr_i[6:2];
    assign status      = {retire_count_i, 14'b0, illegal_q, halted_q};

    // Decode looks at the bus word while idle so illegal_i is known at completion
    assign instr_o = (state_q == ISSUE_IDLE) ? pwdata_i : instr_q;
    assign issue_o = (state_q == ISSUE_EXEC);

    always_comb begin
        prdata_o = '0;
        err      = 1'b0;
        if (pwrite_i) begin
            case (paddr_i)
                ADDR_INSTR: err = illegal_i | halted_q;
                ADDR_PC:    err = 1'b0;
                default:    err = 1'b1;
            endcase
        end else if (reg_hit) begin
            prdata_o = reg_rdata_i;
        end else begin
            case (paddr_i)
                ADDR_PC:     prdata_o = pc_i;
                ADDR_STATUS: prdata_o = status;
                default:     err = 1'b1;
            endcase
        end
    end

    assign pslverr_o = done & err;

    assign instr_wr = done & pwrite_i & (paddr_i == ADDR_INSTR);
    assign start    = instr_wr & ~err;

    assign pc_wen_o   = done & pwrite_i & (paddr_i == ADDR_PC);
    assign pc_wdata_o = pwdata_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ISSUE_IDLE;
            halted_q  <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            case (state_q)
                ISSUE_IDLE: if (start) state_q <= ISSUE_EXEC;
                ISSUE_EXEC: state_q <= ISSUE_WB;
                default:    if (retire_i) state_q <= ISSUE_IDLE;
            endcase
            if (instr_wr && illegal_i) begin
                illegal_q <= 1'b1;
            end
            // Halt word takes effect once it has retired
            if (retire_i && halt_i) begin
                halted_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            instr_q <= pwdata_i;
        end
    end

    assign halted_o = halted_q;

endmodule

// ==== rtl/rv_decode.sv ====
// RV32I decoder producing immediates, operand and writeback selects, ALU op and error flags
`timescale 1ns/10ps
module rv_decode #(
    parameter bit HALT_ON_SELF_LOOP = 1'b1
) (
    input  rv_exec_pkg::word_t     instr_i,
    input  logic                   halted_i,
    output rv_exec_pkg::reg_addr_t rs1_o,
    output rv_exec_pkg::reg_addr_t rs2_o,
    output rv_exec_pkg::reg_addr_t rd_o,
    output rv_exec_pkg::word_t     imm_o,
    output rv_exec_pkg::a_sel_t    a_sel_o,
    output rv_exec_pkg::b_sel_t    b_sel_o,
    output rv_exec_pkg::alu_op_t   alu_op_o,
    output rv_exec_pkg::w_sel_t    w_sel_o,
    output logic                   reg_wen_o,
    output logic                   jump_o,
    output logic                   jalr_o,
    output logic                   illegal_o,
    output logic                   halt_o
);
    import rv_exec_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       shift_imm;
    logic       writes_rd;

    assign opcode = opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    // Bit 30 picks SUB and SRA
    assign alt    = instr_i[30];

    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    assign shift_imm = (opcode == IMMED) && (funct3 == F3_SLLI || funct3 == F3_SRI);

    always_comb begin
        case (opcode)
            LUI, AUIPC: imm_o = {instr_i[31:12], 12'b0};
            // J-type immediate, low bit always zero
            JAL:        imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                 instr_i[30:21], 1'b0};
            default: begin
                if (shift_imm) imm_o = {27'b0, instr_i[24:20]};
                else imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            end
        endcase
    end

    assign a_sel_o = (opcode == AUIPC || opcode == JAL) ? A_PC : A_RS1;
    assign b_sel_o = (opcode == REGREG) ? B_RS2 : B_IMM;

    always_comb begin
        case (opcode)
            JAL, JALR: w_sel_o = W_LINK;
            LUI:       w_sel_o = W_UPPER;
            default:   w_sel_o = W_ALU;
        endcase
    end

    always_comb begin
        alu_op_o = ALU_ADD;
        if (opcode == IMMED || opcode == REGREG) begin
            case (funct3)
                F3_ADDSUB: alu_op_o = (opcode == REGREG && alt) ? ALU_SUB : ALU_ADD;
                F3_SLL:    alu_op_o = ALU_SLL;
                F3_SLT:    alu_op_o = ALU_SLT;
                F3_SLTU:   alu_op_o = ALU_SLTU;
                F3_XOR:    alu_op_o = ALU_XOR;
                F3_SR:     alu_op_o = alt ? ALU_SRA : ALU_SRL;
                F3_OR:     alu_op_o = ALU_OR;
                default:   alu_op_o = ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            REGREG: illegal_o = instr_i[25];
            IMMED, LUI, AUIPC, JAL, JALR: illegal_o = 1'b0;
            default: illegal_o = 1'b1;
        endcase
    end

    // Every kept class writes rd
    assign writes_rd = ~illegal_o;

    // Once halted, nothing may touch architectural state
    assign reg_wen_o = writes_rd & ~halted_i;
    assign jump_o    = (opcode == JAL || opcode == JALR) & ~halted_i;
    assign jalr_o    = (opcode == JALR);

    // jal x0,0 spins forever, treated as end of program
    assign halt_o = HALT_ON_SELF_LOOP && (instr_i == 32'h0000_006f);

endmodule

// ==== rtl/rv_exec_pkg.sv ====
// RV32I execution subsystem shared types, decode encodings and APB register map
package rv_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] apb_addr_t;

    // Major opcodes kept by this core, everything else decodes as illegal
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        IMMED  = 7'b0010011,
        REGREG = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    typedef enum logic {A_RS1, A_PC} a_sel_t;
    typedef enum logic {B_RS2, B_IMM} b_sel_t;

    typedef enum logic [1:0] {W_ALU, W_LINK, W_UPPER} w_sel_t;

    // IMMED funct3
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLLI  = 3'b001;
    localparam logic [2:0] F3_SLTI  = 3'b010;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_SRI   = 3'b101;
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;

    // REGREG funct3
    localparam logic [2:0] F3_ADDSUB = 3'b000;
    localparam logic [2:0] F3_SLL    = 3'b001;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_SLTU   = 3'b011;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_SR     = 3'b101;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;

    // APB map, registers x0..x31 occupy 0x080 to 0x0FC
    localparam apb_addr_t ADDR_INSTR    = 12'h000;
    localparam apb_addr_t ADDR_PC       = 12'h004;
    localparam apb_addr_t ADDR_STATUS   = 12'h008;
    localparam apb_addr_t ADDR_REG_BASE = 12'h080;

    typedef enum logic [1:0] {ISSUE_IDLE, ISSUE_EXEC, ISSUE_WB} issue_state_t;

endpackage

// ==== rtl/rv_exec_top.sv ====
// RV32I execution subsystem top, APB issue driving decode, execute, writeback and registers
`timescale 1ns/10ps
module rv_exec_top #(
    parameter rv_exec_pkg::word_t RESET_PC          = '0,
    parameter bit                 HALT_ON_SELF_LOOP = 1'b1
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  rv_exec_pkg::apb_addr_t paddr_i,
    input  rv_exec_pkg::word_t     pwdata_i,
    output rv_exec_pkg::word_t     prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o
);
    import rv_exec_pkg::*;

    word_t     instr;
    logic      issue;
    logic      halted;
    reg_addr_t reg_raddr;
    logic      pc_wen;
    word_t     pc_wdata;
    word_t     pc;
    logic      retire;
    logic [15:0] retire_count;

    // Decode outputs
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    a_sel_t    a_sel;
    b_sel_t    b_sel;
    alu_op_t   alu_op;
    w_sel_t    w_sel;
    logic      reg_wen;
    logic      jump;
    logic      jalr;
    logic      illegal;
    logic      halt;

    // Execute stage
    logic      ex_valid;
    word_t     ex_result;
    word_t     ex_imm;
    w_sel_t    ex_w_sel;
    logic      ex_wen;
    reg_addr_t ex_rd;
    logic      ex_jump;
    word_t     ex_target;

    // Register file ports
    word_t     rdata1;
    word_t     rdata2;
    word_t     rdata3;
    logic      wb_wen;
    reg_addr_t wb_rd;
    word_t     wb_wdata;

    rv_apb_issue rv_apb_issue_i (
        .clk_i, .rst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .illegal_i(illegal), .halt_i(halt), .retire_i(retire), .pc_i(pc),
        .retire_count_i(retire_count), .reg_rdata_i(rdata3),
        .instr_o(instr), .issue_o(issue), .halted_o(halted), .reg_raddr_o(reg_raddr),
        .pc_wen_o(pc_wen), .pc_wdata_o(pc_wdata)
    );

    rv_decode #(.HALT_ON_SELF_LOOP(HALT_ON_SELF_LOOP)) rv_decode_i (
        .instr_i(instr), .halted_i(halted),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
        .a_sel_o(a_sel), .b_sel_o(b_sel), .alu_op_o(alu_op), .w_sel_o(w_sel),
        .reg_wen_o(reg_wen), .jump_o(jump), .jalr_o(jalr),
        .illegal_o(illegal), .halt_o(halt)
    );

    rv_reg_file rv_reg_file_i (
        .clk_i, .rst_n_i,
        .rs1_i(rs1), .rs2_i(rs2), .rs3_i(reg_raddr),
        .wen_i(wb_wen), .rd_i(wb_rd), .wdata_i(wb_wdata),
        .rdata1_o(rdata1), .rdata2_o(rdata2), .rdata3_o(rdata3)
    );

    rv_execute rv_execute_i (
        .clk_i, .rst_n_i, .issue_i(issue),
        .rdata1_i(rdata1), .rdata2_i(rdata2), .pc_i(pc), .imm_i(imm),
        .a_sel_i(a_sel), .b_sel_i(b_sel), .alu_op_i(alu_op), .w_sel_i(w_sel),
        .reg_wen_i(reg_wen), .rd_i(rd), .jump_i(jump), .jalr_i(jalr),
        .ex_valid_o(ex_valid), .ex_result_o(ex_result), .ex_imm_o(ex_imm),
        .ex_w_sel_o(ex_w_sel), .ex_wen_o(ex_wen), .ex_rd_o(ex_rd),
        .ex_jump_o(ex_jump), .ex_target_o(ex_target)
    );

    rv_result #(.RESET_PC(RESET_PC)) rv_result_i (
        .clk_i, .rst_n_i,
        .ex_valid_i(ex_valid), .ex_result_i(ex_result), .ex_imm_i(ex_imm),
        .ex_w_sel_i(ex_w_sel), .ex_wen_i(ex_wen), .ex_rd_i(ex_rd),
        .ex_jump_i(ex_jump), .ex_target_i(ex_target),
        .pc_wen_i(pc_wen), .pc_wdata_i(pc_wdata),
        .pc_o(pc), .reg_wen_o(wb_wen), .reg_rd_o(wb_rd), .reg_wdata_o(wb_wdata),
        .retire_o(retire), .retire_count_o(retire_count)
    );

endmodule

// ==== rtl/rv_execute.sv ====
// Execute stage with operand muxing, ALU, jump target and result register
`timescale 1ns/10ps
module rv_execute (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   issue_i,
    input  rv_exec_pkg::word_t     rdata1_i,
    input  rv_exec_pkg::word_t     rdata2_i,
    input  rv_exec_pkg::word_t     pc_i,
    input  rv_exec_pkg::word_t     imm_i,
    input  rv_exec_pkg::a_sel_t    a_sel_i,
    input  rv_exec_pkg::b_sel_t    b_sel_i,
    input  rv_exec_pkg::alu_op_t   alu_op_i,
    input  rv_exec_pkg::w_sel_t    w_sel_i,
    input  logic                   reg_wen_i,
    input  rv_exec_pkg::reg_addr_t rd_i,
    input  logic                   jump_i,
    input  logic                   jalr_i,
    output logic                   ex_valid_o,
    output rv_exec_pkg::word_t     ex_result_o,
    output rv_exec_pkg::word_t     ex_imm_o,
    output rv_exec_pkg::w_sel_t    ex_w_sel_o,
    output logic                   ex_wen_o,
    output rv_exec_pkg::reg_addr_t ex_rd_o,
    output logic                   ex_jump_o,
    output rv_exec_pkg::word_t     ex_target_o
);
    import rv_exec_pkg::*;

    word_t    op_a;
    word_t    op_b;
    word_t    alu_res;
    word_t    target;
    logic [4:0] shamt;

    assign op_a  = (a_sel_i == A_PC) ? pc_i : rdata1_i;
    assign op_b  = (b_sel_i == B_IMM) ? imm_i : rdata2_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(op_a) >>> shamt);
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            default:  alu_res = op_a + op_b;
        endcase
    end

    // JAL adds PC+imm, JALR adds rs1+imm, both through the ALU adder
    assign target = {alu_res[31:1], alu_res[0] & ~jalr_i};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
            ex_wen_o   <= 1'b0;
            ex_jump_o  <= 1'b0;
            ex_w_sel_o <= W_ALU;
        end else begin
            ex_valid_o <= issue_i;
            if (issue_i) begin
                ex_wen_o   <= reg_wen_i;
                ex_jump_o  <= jump_i;
                ex_w_sel_o <= w_sel_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            ex_result_o <= alu_res;
            ex_imm_o    <= imm_i;
            ex_rd_o     <= rd_i;
            ex_target_o <= target;
        end
    end

endmodule

// ==== rtl/rv_reg_file.sv ====
// Integer register file, 32 x 32 bits, two operand read ports and one host read port
`timescale 1ns/10ps
module rv_reg_file (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  rv_exec_pkg::reg_addr_t rs1_i,
    input  rv_exec_pkg::reg_addr_t rs2_i,
    input  rv_exec_pkg::reg_addr_t rs3_i,
    input  logic                   wen_i,
    input  rv_exec_pkg::reg_addr_t rd_i,
    input  rv_exec_pkg::word_t     wdata_i,
    output rv_exec_pkg::word_t     rdata1_o,
    output rv_exec_pkg::word_t     rdata2_o,
    output rv_exec_pkg::word_t     rdata3_o
);
    import rv_exec_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && rd_i != '0) begin
            // x0 is never written so it reads back zero
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[rs1_i];
    assign rdata2_o = regs[rs2_i];
    assign rdata3_o = regs[rs3_i];

endmodule

// ==== rtl/rv_result.sv ====
// Writeback stage selecting register data, updating the PC and counting retirements
`timescale 1ns/10ps
module rv_result #(
    parameter rv_exec_pkg::word_t RESET_PC = '0
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   ex_valid_i,
    input  rv_exec_pkg::word_t     ex_result_i,
    input  rv_exec_pkg::word_t     ex_imm_i,
    input  rv_exec_pkg::w_sel_t    ex_w_sel_i,
    input  logic                   ex_wen_i,
    input  rv_exec_pkg::reg_addr_t ex_rd_i,
    input  logic                   ex_jump_i,
    input  rv_exec_pkg::word_t     ex_target_i,
    input  logic                   pc_wen_i,
    input  rv_exec_pkg::word_t     pc_wdata_i,
    output rv_exec_pkg::word_t     pc_o,
    output logic                   reg_wen_o,
    output rv_exec_pkg::reg_addr_t reg_rd_o,
    output rv_exec_pkg::word_t     reg_wdata_o,
    output logic                   retire_o,
    output logic [15:0]            retire_count_o
);
    import rv_exec_pkg::*;

    word_t pc_q;
    word_t pc_plus4;

    assign pc_plus4 = pc_q + 32'd4;

    always_comb begin
        case (ex_w_sel_i)
            W_LINK:  reg_wdata_o = pc_plus4;
            W_UPPER: reg_wdata_o = ex_imm_i;
            default: reg_wdata_o = ex_result_i;
        endcase
    end

    assign reg_wen_o = ex_valid_i & ex_wen_i;
    assign reg_rd_o  = ex_rd_i;
    assign retire_o  = ex_valid_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q           <= RESET_PC;
            retire_count_o <= '0;
        end else if (ex_valid_i) begin
            pc_q           <= ex_jump_i ? ex_target_i : pc_plus4;
            retire_count_o <= retire_count_o + 16'd1;
        end else if (pc_wen_i) begin
            // Host override, only reaches here while the pipe is empty
            pc_q <= pc_wdata_i;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_exec_tb -f project.f -o rv_exec_sim
./obj_dir/rv_exec_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== tb/rv_exec_props.sv ====
// APB response and issue pipeline assertions bound into the APB issue block
`timescale 1ns/10ps
module rv_exec_props (
    input logic                        clk_i,
    input logic                        rst_n_i,
    input logic                        psel_i,
    input logic                        penable_i,
    input logic                        pwrite_i,
    input rv_exec_pkg::apb_addr_t      paddr_i,
    input logic                        pready_i,
    input logic                        pslverr_i,
    input rv_exec_pkg::issue_state_t   state_i,
    input logic                        retire_i
);
    import rv_exec_pkg::*;

    logic accept;
    logic rejected;

    // Instruction write that completes without an error response
    assign accept = psel_i & penable_i & pready_i & pwrite_i & ~pslverr_i
                    & (paddr_i == ADDR_INSTR);

    // Instruction write answered with an error response
    assign rejected = pslverr_i & pwrite_i & (paddr_i == ADDR_INSTR);

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rejected |=> (state_i == ISSUE_IDLE))
        else $error("instruction answered with pslverr was started");

    // Two busy cycles hold off the bus, then it is ready again
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |=> !pready_i ##1 !pready_i ##1 pready_i)
        else $error("pready did not hold off the bus for two cycles after an issue");

    // Retire follows an accepted instruction by exactly two edges
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(accept, 2) |-> retire_i)
        else $error("accepted instruction did not retire two cycles later");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_i |-> $past(accept, 2))
        else $error("retire without an instruction accepted two cycles earlier");

endmodule

bind rv_apb_issue rv_exec_props rv_exec_props_i (
    .clk_i,
    .rst_n_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pready_i(pready_o),
    .pslverr_i(pslverr_o),
    .state_i(state_q),
    .retire_i
);

// ==== tb/rv_exec_tb.sv ====
// Table-driven APB testbench for the RV32I execution subsystem
`timescale 1ns/10ps
module rv_exec_tb;
    import rv_exec_pkg::*;

    localparam int    PERIOD_NS    = 40;
    localparam int    RESET_CYCLES = 8;
    localparam int    QUARTER_NS   = PERIOD_NS / 4;
    localparam word_t START_PC     = 32'h0000_0200;

    typedef enum logic [2:0] {
        OP_WR_INSTR,
        OP_WR_PC,
        OP_RD_REG,
        OP_RD_PC,
        OP_RD_STATUS,
        OP_WR_RAW,
        OP_RD_RAW
    } op_e;

    typedef struct packed {
        op_e       op;
        apb_addr_t addr;
        word_t     data;
        word_t     exp;
        logic      exp_err;
        logic      chk;
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;

    row_t rows[$];
    logic rows_ready;
    int   mismatches;
    logic row_ok;

    // Architectural state as predicted while rows are added
    word_t       pc_model;
    logic [15:0] retired;
    logic        ill_seen;
    logic        halted_model;
    integer      seed;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_i (
        .clk_o(clk),
        .rst_n_o(rst_n)
    );

    rv_exec_top #(.RESET_PC(START_PC), .HALT_ON_SELF_LOOP(1'b1)) rv_exec_top_i (
        .clk_i(clk),
        .rst_n_i(rst_n),
        .psel_i(psel),
        .penable_i(penable),
        .pwrite_i(pwrite),
        .paddr_i(paddr),
        .pwdata_i(pwdata),
        .prdata_o(prdata),
        .pready_o(pready),
        .pslverr_o(pslverr)
    );

    // RV32I instruction formats
    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_j(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic string op_name(op_e op);
        case (op)
            OP_WR_INSTR:  return "write instr";
            OP_WR_PC:     return "write pc";
            OP_RD_REG:    return "read reg";
            OP_RD_PC:     return "read pc";
            OP_RD_STATUS: return "read status";
            OP_WR_RAW:    return "write addr";
            default:      return "read addr";
        endcase
    endfunction

    task automatic add_row(op_e op, apb_addr_t addr, word_t data, word_t exp,
                           logic exp_err, logic chk);
        row_t r;
        r.op      = op;
        r.addr    = addr;
        r.data    = data;
        r.exp     = exp;
        r.exp_err = exp_err;
        r.chk     = chk;
        rows.push_back(r);
    endtask

    task automatic issue_jump(word_t instr, word_t target);
        add_row(OP_WR_INSTR, ADDR_INSTR, instr, '0, 1'b0, 1'b0);
        pc_model = target;
        retired  = retired + 16'd1;
    endtask

    task automatic issue_seq(word_t instr);
        issue_jump(instr, pc_model + 32'd4);
    endtask

    task automatic issue_rejected(word_t instr, logic is_illegal);
        add_row(OP_WR_INSTR, ADDR_INSTR, instr, '0, 1'b1, 1'b0);
        if (is_illegal) begin
            ill_seen = 1'b1;
        end
    endtask

    task automatic expect_reg(int idx, word_t val);
        add_row(OP_RD_REG, ADDR_REG_BASE + apb_addr_t'(idx * 4), '0, val, 1'b0, 1'b1);
    endtask

    task automatic expect_pc();
        add_row(OP_RD_PC, ADDR_PC, '0, pc_model, 1'b0, 1'b1);
    endtask

    task automatic expect_status();
        add_row(OP_RD_STATUS, ADDR_STATUS, '0, {retired, 14'b0, ill_seen, halted_model},
                1'b0, 1'b1);
    endtask

    task automatic set_pc(word_t val);
        add_row(OP_WR_PC, ADDR_PC, val, '0, 1'b0, 1'b0);
        pc_model = val;
    endtask

    task automatic build_rows();
        integer      rnd;
        logic [11:0] imm;
        word_t       acc;
        word_t       link;
        reg_addr_t   src;
        pc_model     = START_PC;
        retired      = '0;
        ill_seen     = 1'b0;
        halted_model = 1'b0;
        seed         = 78;

        // Immediate, shift and upper forms
        issue_seq(enc_i(12'd5, 5'd0, F3_ADDI, 5'd1, IMMED));
        expect_reg(1, 32'd5);
        issue_seq(enc_i(12'hFFD, 5'd0, F3_ADDI, 5'd2, IMMED));
        expect_reg(2, 32'hFFFF_FFFD);
        issue_seq(enc_i(12'd1, 5'd2, F3_SLTI, 5'd3, IMMED));
        expect_reg(3, 32'd1);
        issue_seq(enc_i(12'd1, 5'd2, F3_SLTIU, 5'd4, IMMED));
        expect_reg(4, 32'd0);
        issue_seq(enc_i(12'h0F0, 5'd1, F3_XORI, 5'd5, IMMED));
        expect_reg(5, 32'h0000_00F5);
        issue_seq(enc_i(12'd4, 5'd1, F3_SLLI, 5'd6, IMMED));
        expect_reg(6, 32'h0000_0050);
        issue_seq(enc_i(12'd28, 5'd2, F3_SRI, 5'd7, IMMED));
        expect_reg(7, 32'h0000_000F);
        // SRAI carries bit 30 in the immediate field
        issue_seq(enc_i(12'h401, 5'd2, F3_SRI, 5'd8, IMMED));
        expect_reg(8, 32'hFFFF_FFFE);
        issue_seq(enc_u(20'h12345, 5'd9, LUI));
        expect_reg(9, 32'h1234_5000);
        link = pc_model + 32'h0000_1000;
        issue_seq(enc_u(20'h00001, 5'd10, AUIPC));
        expect_reg(10, link);
        issue_seq(enc_i(12'd7, 5'd1, F3_ADDI, 5'd0, IMMED));
        expect_reg(0, 32'd0);

        // Random ADDI chain starting from x1
        acc = 32'd5;
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            imm = rnd[11:0];
            src = (k == 0) ? 5'd1 : reg_addr_t'(10 + k);
            acc = acc + {{20{imm[11]}}, imm};
            issue_seq(enc_i(imm, src, F3_ADDI, reg_addr_t'(11 + k), IMMED));
            expect_reg(11 + k, acc);
        end

        // Register-register on x1 = 5, x2 = -3, x6 = 0x50
        issue_seq(enc_r(7'h00, 5'd2, 5'd1, F3_ADDSUB, 5'd19));
        expect_reg(19, 32'd2);
        issue_seq(enc_r(7'h20, 5'd2, 5'd1, F3_ADDSUB, 5'd20));
        expect_reg(20, 32'd8);
        issue_seq(enc_r(7'h00, 5'd1, 5'd1, F3_SLL, 5'd21));
        expect_reg(21, 32'h0000_00A0);
        issue_seq(enc_r(7'h00, 5'd1, 5'd2, F3_SLT, 5'd22));
        expect_reg(22, 32'd1);
        issue_seq(enc_r(7'h00, 5'd1, 5'd2, F3_SLTU, 5'd23));
        expect_reg(23, 32'd0);
        issue_seq(enc_r(7'h20, 5'd1, 5'd2, F3_SR, 5'd24));
        expect_reg(24, 32'hFFFF_FFFF);
        issue_seq(enc_r(7'h00, 5'd6, 5'd2, F3_AND, 5'd25));
        expect_reg(25, 32'h0000_0050);
        issue_seq(enc_r(7'h00, 5'd6, 5'd1, F3_OR, 5'd26));
        expect_reg(26, 32'h0000_0055);

        // Control flow and host PC writes
        expect_pc();
        set_pc(32'h0000_0400);
        expect_pc();
        link = pc_model + 32'd4;
        issue_jump(enc_j(21'd16, 5'd27), pc_model + 32'd16);
        expect_reg(27, link);
        expect_pc();
        issue_seq(enc_i(12'h123, 5'd0, F3_ADDI, 5'd28, IMMED));
        link = pc_model + 32'd4;
        // JALR drops bit 0 of the odd sum x27 + 0x1FD
        issue_jump(enc_i(12'h1FD, 5'd27, 3'b000, 5'd29, JALR),
                   (32'h0000_0404 + 32'h0000_01FD) & ~32'h1);
        expect_reg(29, link);
        expect_reg(28, 32'h0000_0123);
        expect_pc();
        link = pc_model + 32'd4;
        issue_jump(enc_j(21'h1F_FF00, 5'd30), pc_model - 32'h0000_0100);
        expect_reg(30, link);
        expect_pc();
        expect_status();

        // Error responses
        issue_rejected(enc_i(12'd0, 5'd0, 3'b010, 5'd31, 7'b0000011), 1'b1);
        expect_reg(31, 32'd0);
        issue_rejected(enc_r(7'h01, 5'd1, 5'd1, F3_ADDSUB, 5'd1), 1'b1);
        expect_reg(1, 32'd5);
        expect_status();
        add_row(OP_WR_RAW, ADDR_STATUS, 32'h1, '0, 1'b1, 1'b0);
        add_row(OP_RD_RAW, 12'h010, '0, '0, 1'b1, 1'b0);
        expect_pc();

        // jal x0,0 halts and later words are refused
        issue_jump(enc_j(21'd0, 5'd0), pc_model);
        halted_model = 1'b1;
        expect_status();
        expect_pc();
        issue_rejected(enc_i(12'd99, 5'd0, F3_ADDI, 5'd1, IMMED), 1'b0);
        expect_reg(1, 32'd5);
        expect_status();
    endtask

    task automatic compare_word(string what, word_t got, word_t want);
        if (got !== want) begin
            $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, want);
            mismatches++;
            row_ok = 1'b0;
        end
    endtask

    // One APB transfer sampled a quarter period after the falling edge
    task automatic apb_xfer(input logic write, input apb_addr_t addr, input word_t wdata,
                            output word_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(QUARTER_NS);
        while (pready !== 1'b1) begin
            @(negedge clk);
            #(QUARTER_NS);
        end
        rdata = prdata;
        err   = pslverr;
        // Completing edge, the next setup phase follows straight after it
        @(posedge clk);
    endtask

    initial begin : main
        word_t rdata;
        logic  err;
        logic  is_write;
        int    passed;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        mismatches = 0;
        passed     = 0;
        row_ok     = 1'b1;
        rows_ready = 1'b0;
        build_rows();
        rows_ready = 1'b1;
        wait (rst_n === 1'b1);
        for (int i = 0; i < rows.size(); i++) begin
            row_ok   = 1'b1;
            is_write = (rows[i].op == OP_WR_INSTR) || (rows[i].op == OP_WR_PC) ||
                       (rows[i].op == OP_WR_RAW);
            apb_xfer(is_write, rows[i].addr, rows[i].data, rdata, err);
            compare_word("pslverr", {31'b0, err}, {31'b0, rows[i].exp_err});
            if (rows[i].chk) begin
                compare_word("read data", rdata, rows[i].exp);
            end
            $display("test %0d %s at %h: %s", i, op_name(rows[i].op), rows[i].addr,
                     row_ok ? "ok" : "wrong");
            if (row_ok) begin
                passed++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed", rows.size(), passed,
                 rows.size() - passed);
        if (mismatches == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Each row gets 20 cycles which is far more than a busy transfer needs
    initial begin : watchdog
        int limit;
        wait (rows_ready === 1'b1);
        limit = rows.size() * 20 + RESET_CYCLES;
        repeat (limit) @(posedge clk);
        $display("timeout: the table did not finish within %0d clock cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and active-low reset source
`timescale 1ns/10ps
module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release reset on a falling edge, away from the active clock edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule
